// File: src/mips_pkg.sv
package mips_pkg;

   // datapath widths
   localparam int NB_DATA  = 32;
   localparam int NB_REG   = 5;
   localparam int NB_IADDR = 6;
   localparam int NB_DADDR = 6;
   localparam int NB_FIELD = 6;

   typedef logic [NB_DATA-1:0]  word_t;
   typedef logic [NB_REG-1:0]   reg_idx_t;
   typedef logic [NB_IADDR-1:0] iaddr_t;
   typedef logic [NB_FIELD-1:0] field_t;

   // all-zero word decodes as sll r0 and retires nothing
   localparam word_t NOP = '0;

   // primary opcodes
   localparam field_t OP_RTYPE = 6'h00;
   localparam field_t OP_J     = 6'h02;
   localparam field_t OP_BEQ   = 6'h04;
   localparam field_t OP_ADDI  = 6'h08;
   localparam field_t OP_LW    = 6'h23;
   localparam field_t OP_SW    = 6'h2b;

   // r-type function codes
   localparam field_t FN_ADDU = 6'h21;
   localparam field_t FN_SUBU = 6'h23;
   localparam field_t FN_AND  = 6'h24;
   localparam field_t FN_OR   = 6'h25;
   localparam field_t FN_SLT  = 6'h2a;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_e;

   // operand source for the execute muxes
   typedef enum logic [1:0] {
      FWD_REG,
      FWD_EXMEM,
      FWD_MEMWB
   } fwd_sel_e;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic             i_imem_we,
   input  mips_pkg::iaddr_t i_imem_addr,
   input  mips_pkg::word_t  i_imem_wdata,
   input  logic             i_stall,
   input  logic             i_redirect,
   input  mips_pkg::word_t  i_tgt,
   output mips_pkg::word_t  o_pc,
   output mips_pkg::word_t  o_instr
);

   mips_pkg::word_t  imem [2**mips_pkg::NB_IADDR];
   mips_pkg::word_t  pc;
   mips_pkg::word_t  pc_plus4;
   mips_pkg::iaddr_t fetch_addr;

   assign fetch_addr = pc[mips_pkg::NB_IADDR+1:2];
   assign pc_plus4   = pc + 32'd4;

   // program load, one word per cycle
   always_ff @(posedge i_clk) begin
      if (i_imem_we) begin
         imem[i_imem_addr] <= i_imem_wdata;
      end
   end

   // pc and if/id register
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc      <= '0;
         o_pc    <= '0;
         o_instr <= mips_pkg::NOP;
      end else if (i_redirect) begin
         // word fetched this cycle is the squashed slot
         pc      <= i_tgt;
         o_pc    <= i_tgt;
         o_instr <= mips_pkg::NOP;
      end else if (!i_stall) begin
         pc      <= pc_plus4;
         o_pc    <= pc_plus4;
         o_instr <= imem[fetch_addr];
      end
   end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
   input  logic                i_clk,
   input  logic                i_rst,
   input  mips_pkg::word_t     i_pc,
   input  mips_pkg::word_t     i_instr,
   input  logic                i_wb_en,
   input  mips_pkg::reg_idx_t  i_wb_reg,
   input  mips_pkg::word_t     i_wb_data,
   input  logic                i_bubble,
   output logic                o_redirect,
   output mips_pkg::word_t     o_tgt,
   output mips_pkg::word_t     o_rs_val,
   output mips_pkg::word_t     o_rt_val,
   output mips_pkg::word_t     o_imm,
   output mips_pkg::reg_idx_t  o_rs,
   output mips_pkg::reg_idx_t  o_rt,
   output mips_pkg::reg_idx_t  o_rd,
   output mips_pkg::alu_op_e   o_alu_op,
   output logic                o_alu_imm,
   output logic                o_reg_we,
   output logic                o_mem_rd,
   output logic                o_mem_we,
   output logic                o_mem_to_reg,
   output mips_pkg::reg_idx_t  o_if_rs,
   output mips_pkg::reg_idx_t  o_if_rt,
   output logic                o_if_branch
);

   mips_pkg::word_t    rf [2**mips_pkg::NB_REG];
   mips_pkg::field_t   opcode;
   mips_pkg::field_t   funct;
   mips_pkg::reg_idx_t rs;
   mips_pkg::reg_idx_t rt;
   mips_pkg::reg_idx_t rd;
   mips_pkg::word_t    imm_ext;
   mips_pkg::word_t    rs_val;
   mips_pkg::word_t    rt_val;
   mips_pkg::alu_op_e  alu_op;
   logic               alu_imm;
   logic               reg_we;
   logic               mem_rd;
   logic               mem_we;
   logic               mem_to_reg;
   logic               dst_rt;
   logic               uses_rs;
   logic               uses_rt;
   logic               is_beq;
   logic               is_j;

   assign opcode  = i_instr[31:26];
   assign rs      = i_instr[25:21];
   assign rt      = i_instr[20:16];
   assign rd      = i_instr[15:11];
   assign funct   = i_instr[5:0];
   assign imm_ext = {{16{i_instr[15]}}, i_instr[15:0]};

   // register read, r0 is hardwired and writeback wins
   function automatic mips_pkg::word_t rf_read(input mips_pkg::reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end
      if (i_wb_en && (i_wb_reg == idx)) begin
         return i_wb_data;
      end
      return rf[idx];
   endfunction

   always_comb begin
      rs_val = rf_read(rs);
      rt_val = rf_read(rt);
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < 2**mips_pkg::NB_REG; i++) begin
            rf[i] <= '0;
         end
      end else if (i_wb_en) begin
         rf[i_wb_reg] <= i_wb_data;
      end
   end

   // main decoder
   always_comb begin
      alu_op = mips_pkg::ALU_ADD;
      {alu_imm, reg_we, mem_rd, mem_we, mem_to_reg} = '0;
      {dst_rt, uses_rs, uses_rt, is_beq, is_j} = '0;
      case (opcode)
         mips_pkg::OP_RTYPE: begin
            {uses_rs, uses_rt, reg_we} = 3'b111;
            case (funct)
               mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
               default:           reg_we = 1'b0;
            endcase
         end
         mips_pkg::OP_ADDI: {uses_rs, alu_imm, reg_we, dst_rt} = 4'b1111;
         mips_pkg::OP_LW:   {uses_rs, alu_imm, reg_we, dst_rt, mem_rd, mem_to_reg} = 6'h3f;
         mips_pkg::OP_SW:   {uses_rs, uses_rt, alu_imm, mem_we} = 4'b1111;
         mips_pkg::OP_BEQ:  {uses_rs, uses_rt, is_beq} = 3'b111;
         mips_pkg::OP_J:    is_j = 1'b1;
         default:           is_j = 1'b0;
      endcase
   end

   // unused source fields read as r0 so they never match a hazard
   assign o_if_rs     = uses_rs ? rs : '0;
   assign o_if_rt     = uses_rt ? rt : '0;
   assign o_if_branch = is_beq;

   // branch resolves here, held back while operands are in flight
   assign o_redirect = ((is_beq && (rs_val == rt_val)) || is_j) && !i_bubble;
   assign o_tgt      = is_j ? {i_pc[31:28], i_instr[25:0], 2'b00}
                            : i_pc + {imm_ext[29:0], 2'b00};

   // id/ex controls
   always_ff @(posedge i_clk) begin
      if (i_rst || i_bubble) begin
         o_alu_op <= mips_pkg::ALU_ADD;
         {o_alu_imm, o_reg_we, o_mem_rd, o_mem_we, o_mem_to_reg} <= '0;
      end else begin
         o_alu_op     <= alu_op;
         o_alu_imm    <= alu_imm;
         o_reg_we     <= reg_we;
         o_mem_rd     <= mem_rd;
         o_mem_we     <= mem_we;
         o_mem_to_reg <= mem_to_reg;
      end
   end

   // id/ex payload
   always_ff @(posedge i_clk) begin
      o_rs_val <= rs_val;
      o_rt_val <= rt_val;
      o_imm    <= imm_ext;
      o_rs     <= o_if_rs;
      o_rt     <= o_if_rt;
      o_rd     <= dst_rt ? rt : rd;
   end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
   input  logic               i_clk,
   input  logic               i_rst,
   input  mips_pkg::word_t    i_rs_val,
   input  mips_pkg::word_t    i_rt_val,
   input  mips_pkg::word_t    i_imm,
   input  mips_pkg::reg_idx_t i_rd,
   input  mips_pkg::alu_op_e  i_alu_op,
   input  logic               i_alu_imm,
   input  logic               i_reg_we,
   input  logic               i_mem_rd,
   input  logic               i_mem_we,
   input  logic               i_mem_to_reg,
   input  mips_pkg::fwd_sel_e i_fwd_a,
   input  mips_pkg::fwd_sel_e i_fwd_b,
   input  mips_pkg::word_t    i_exmem_val,
   input  mips_pkg::word_t    i_memwb_val,
   output mips_pkg::word_t    o_alu,
   output mips_pkg::word_t    o_store,
   output mips_pkg::reg_idx_t o_dst,
   output logic               o_reg_we,
   output logic               o_mem_rd,
   output logic               o_mem_we,
   output logic               o_mem_to_reg
);

   mips_pkg::word_t op_a;
   mips_pkg::word_t op_b;
   mips_pkg::word_t store_val;
   mips_pkg::word_t alu_res;

   function automatic mips_pkg::word_t fwd_mux(input mips_pkg::fwd_sel_e sel,
                                               input mips_pkg::word_t    reg_val);
      case (sel)
         mips_pkg::FWD_EXMEM: return i_exmem_val;
         mips_pkg::FWD_MEMWB: return i_memwb_val;
         default:             return reg_val;
      endcase
   endfunction

   always_comb begin
      op_a      = fwd_mux(i_fwd_a, i_rs_val);
      // rt path also carries the store data
      store_val = fwd_mux(i_fwd_b, i_rt_val);
      op_b      = i_alu_imm ? i_imm : store_val;
      case (i_alu_op)
         mips_pkg::ALU_SUB: alu_res = op_a - op_b;
         mips_pkg::ALU_AND: alu_res = op_a & op_b;
         mips_pkg::ALU_OR:  alu_res = op_a | op_b;
         mips_pkg::ALU_SLT: alu_res = {{(mips_pkg::NB_DATA-1){1'b0}},
                                       $signed(op_a) < $signed(op_b)};
         default:           alu_res = op_a + op_b;
      endcase
   end

   // ex/mem controls
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         {o_reg_we, o_mem_rd, o_mem_we, o_mem_to_reg} <= '0;
      end else begin
         o_reg_we     <= i_reg_we;
         o_mem_rd     <= i_mem_rd;
         o_mem_we     <= i_mem_we;
         o_mem_to_reg <= i_mem_to_reg;
      end
   end

   always_ff @(posedge i_clk) begin
      o_alu   <= alu_res;
      o_store <= store_val;
      o_dst   <= i_rd;
   end

endmodule

// File: src/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
   input  logic               i_clk,
   input  logic               i_rst,
   input  mips_pkg::word_t    i_alu,
   input  mips_pkg::word_t    i_store,
   input  mips_pkg::reg_idx_t i_dst,
   input  logic               i_reg_we,
   input  logic               i_mem_rd,
   input  logic               i_mem_we,
   input  logic               i_mem_to_reg,
   output logic               o_wb_en,
   output mips_pkg::reg_idx_t o_wb_reg,
   output mips_pkg::word_t    o_wb_data
);

   mips_pkg::word_t              dmem [2**mips_pkg::NB_DADDR];
   logic [mips_pkg::NB_DADDR-1:0] d_addr;
   mips_pkg::word_t              load_q;
   mips_pkg::word_t              alu_q;
   logic                         mem_to_reg_q;

   // word addressing, byte offset ignored
   assign d_addr = i_alu[mips_pkg::NB_DADDR+1:2];

   always_ff @(posedge i_clk) begin
      if (i_mem_we) begin
         dmem[d_addr] <= i_store;
      end
   end

   // mem/wb payload
   always_ff @(posedge i_clk) begin
      if (i_mem_rd) begin
         load_q <= dmem[d_addr];
      end
      alu_q    <= i_alu;
      o_wb_reg <= i_dst;
   end

   // writes to r0 are dropped here
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb_en      <= 1'b0;
         mem_to_reg_q <= 1'b0;
      end else begin
         o_wb_en      <= i_reg_we && (i_dst != '0);
         mem_to_reg_q <= i_mem_to_reg;
      end
   end

   assign o_wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
   input  mips_pkg::reg_idx_t i_if_rs,
   input  mips_pkg::reg_idx_t i_if_rt,
   input  logic               i_if_branch,
   input  mips_pkg::reg_idx_t i_idex_rs,
   input  mips_pkg::reg_idx_t i_idex_rt,
   input  mips_pkg::reg_idx_t i_idex_dst,
   input  logic               i_idex_we,
   input  logic               i_idex_mem_rd,
   input  mips_pkg::reg_idx_t i_exmem_dst,
   input  logic               i_exmem_we,
   input  mips_pkg::reg_idx_t i_memwb_dst,
   input  logic               i_memwb_we,
   output mips_pkg::fwd_sel_e o_fwd_a,
   output mips_pkg::fwd_sel_e o_fwd_b,
   output logic               o_stall
);

   logic load_use;
   logic branch_wait;

   // youngest producer wins
   function automatic mips_pkg::fwd_sel_e pick_src(input mips_pkg::reg_idx_t src);
      if (src == '0) begin
         return mips_pkg::FWD_REG;
      end
      if (i_exmem_we && (i_exmem_dst == src)) begin
         return mips_pkg::FWD_EXMEM;
      end
      if (i_memwb_we && (i_memwb_dst == src)) begin
         return mips_pkg::FWD_MEMWB;
      end
      return mips_pkg::FWD_REG;
   endfunction

   // producer writes a source of the instruction in if/id
   function automatic logic hits_if(input logic we, input mips_pkg::reg_idx_t dst);
      return we && (dst != '0) && ((dst == i_if_rs) || (dst == i_if_rt));
   endfunction

   always_comb begin
      o_fwd_a     = pick_src(i_idex_rs);
      o_fwd_b     = pick_src(i_idex_rt);
      load_use    = hits_if(i_idex_mem_rd, i_idex_dst);
      // beq compares in decode, so wait until the writer sits in mem/wb
      branch_wait = i_if_branch &&
                    (hits_if(i_idex_we, i_idex_dst) || hits_if(i_exmem_we, i_exmem_dst));
      o_stall     = load_use || branch_wait;
   end

endmodule

// File: src/mips_core.sv
`timescale 1ns/1ps

module mips_core (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_imem_we,
   input  mips_pkg::iaddr_t   i_imem_addr,
   input  mips_pkg::word_t    i_imem_wdata,
   output logic               o_wb_en,
   output mips_pkg::reg_idx_t o_wb_reg,
   output mips_pkg::word_t    o_wb_data
);

   // fetch and decode
   mips_pkg::word_t    fet_2_dec_pc;
   mips_pkg::word_t    fet_2_dec_instr;
   mips_pkg::word_t    dec_2_fet_tgt;
   logic               dec_2_fet_redirect;

   // id/ex register
   mips_pkg::word_t    dec_2_ex_rs_val;
   mips_pkg::word_t    dec_2_ex_rt_val;
   mips_pkg::word_t    dec_2_ex_imm;
   mips_pkg::reg_idx_t dec_2_hz_rs;
   mips_pkg::reg_idx_t dec_2_hz_rt;
   mips_pkg::reg_idx_t dec_2_ex_dst;
   mips_pkg::alu_op_e  dec_2_ex_alu_op;
   logic               dec_2_ex_alu_imm;
   logic               dec_2_ex_reg_we;
   logic               dec_2_ex_mem_rd;
   logic               dec_2_ex_mem_we;
   logic               dec_2_ex_mem_to_reg;

   // sources of the word in if/id
   mips_pkg::reg_idx_t dec_2_hz_if_rs;
   mips_pkg::reg_idx_t dec_2_hz_if_rt;
   logic               dec_2_hz_if_branch;

   // ex/mem register
   mips_pkg::word_t    ex_2_mem_alu;
   mips_pkg::word_t    ex_2_mem_store;
   mips_pkg::reg_idx_t ex_2_mem_dst;
   logic               ex_2_mem_reg_we;
   logic               ex_2_mem_mem_rd;
   logic               ex_2_mem_mem_we;
   logic               ex_2_mem_mem_to_reg;

   // hazard control
   mips_pkg::fwd_sel_e hz_fwd_a;
   mips_pkg::fwd_sel_e hz_fwd_b;
   logic               hz_stall;

   fetch_stage inst_fetch_stage (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_imem_we    (i_imem_we),
      .i_imem_addr  (i_imem_addr),
      .i_imem_wdata (i_imem_wdata),
      .i_stall      (hz_stall),
      .i_redirect   (dec_2_fet_redirect),
      .i_tgt        (dec_2_fet_tgt),
      .o_pc         (fet_2_dec_pc),
      .o_instr      (fet_2_dec_instr)
   );

   decode_stage inst_decode_stage (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_pc         (fet_2_dec_pc),
      .i_instr      (fet_2_dec_instr),
      .i_wb_en      (o_wb_en),
      .i_wb_reg     (o_wb_reg),
      .i_wb_data    (o_wb_data),
      .i_bubble     (hz_stall),
      .o_redirect   (dec_2_fet_redirect),
      .o_tgt        (dec_2_fet_tgt),
      .o_rs_val     (dec_2_ex_rs_val),
      .o_rt_val     (dec_2_ex_rt_val),
      .o_imm        (dec_2_ex_imm),
      .o_rs         (dec_2_hz_rs),
      .o_rt         (dec_2_hz_rt),
      .o_rd         (dec_2_ex_dst),
      .o_alu_op     (dec_2_ex_alu_op),
      .o_alu_imm    (dec_2_ex_alu_imm),
      .o_reg_we     (dec_2_ex_reg_we),
      .o_mem_rd     (dec_2_ex_mem_rd),
      .o_mem_we     (dec_2_ex_mem_we),
      .o_mem_to_reg (dec_2_ex_mem_to_reg),
      .o_if_rs      (dec_2_hz_if_rs),
      .o_if_rt      (dec_2_hz_if_rt),
      .o_if_branch  (dec_2_hz_if_branch)
   );

   execute_stage inst_execute_stage (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_rs_val     (dec_2_ex_rs_val),
      .i_rt_val     (dec_2_ex_rt_val),
      .i_imm        (dec_2_ex_imm),
      .i_rd         (dec_2_ex_dst),
      .i_alu_op     (dec_2_ex_alu_op),
      .i_alu_imm    (dec_2_ex_alu_imm),
      .i_reg_we     (dec_2_ex_reg_we),
      .i_mem_rd     (dec_2_ex_mem_rd),
      .i_mem_we     (dec_2_ex_mem_we),
      .i_mem_to_reg (dec_2_ex_mem_to_reg),
      .i_fwd_a      (hz_fwd_a),
      .i_fwd_b      (hz_fwd_b),
      .i_exmem_val  (ex_2_mem_alu),
      .i_memwb_val  (o_wb_data),
      .o_alu        (ex_2_mem_alu),
      .o_store      (ex_2_mem_store),
      .o_dst        (ex_2_mem_dst),
      .o_reg_we     (ex_2_mem_reg_we),
      .o_mem_rd     (ex_2_mem_mem_rd),
      .o_mem_we     (ex_2_mem_mem_we),
      .o_mem_to_reg (ex_2_mem_mem_to_reg)
   );

   memory_stage inst_memory_stage (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_alu        (ex_2_mem_alu),
      .i_store      (ex_2_mem_store),
      .i_dst        (ex_2_mem_dst),
      .i_reg_we     (ex_2_mem_reg_we),
      .i_mem_rd     (ex_2_mem_mem_rd),
      .i_mem_we     (ex_2_mem_mem_we),
      .i_mem_to_reg (ex_2_mem_mem_to_reg),
      .o_wb_en      (o_wb_en),
      .o_wb_reg     (o_wb_reg),
      .o_wb_data    (o_wb_data)
   );

   hazard_unit inst_hazard_unit (
      .i_if_rs       (dec_2_hz_if_rs),
      .i_if_rt       (dec_2_hz_if_rt),
      .i_if_branch   (dec_2_hz_if_branch),
      .i_idex_rs     (dec_2_hz_rs),
      .i_idex_rt     (dec_2_hz_rt),
      .i_idex_dst    (dec_2_ex_dst),
      .i_idex_we     (dec_2_ex_reg_we),
      .i_idex_mem_rd (dec_2_ex_mem_rd),
      .i_exmem_dst   (ex_2_mem_dst),
      .i_exmem_we    (ex_2_mem_reg_we),
      .i_memwb_dst   (o_wb_reg),
      .i_memwb_we    (o_wb_en),
      .o_fwd_a       (hz_fwd_a),
      .o_fwd_b       (hz_fwd_b),
      .o_stall       (hz_stall)
   );

endmodule

// File: sim/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

   localparam int N_TESTS  = 5;
   localparam int PROG_LEN = 12;

   logic               clk = 1'b0;
   logic               rst = 1'b1;
   logic               imem_we = 1'b0;
   mips_pkg::iaddr_t   imem_addr = '0;
   mips_pkg::word_t    imem_wdata = '0;
   logic               wb_en;
   mips_pkg::reg_idx_t wb_reg;
   mips_pkg::word_t    wb_data;

   // test table
   string              names [N_TESTS];
   mips_pkg::word_t    prog [N_TESTS][PROG_LEN];
   int                 n_wb [N_TESTS];

   // expected writes in program order
   mips_pkg::reg_idx_t exp_reg [$];
   mips_pkg::word_t    exp_val [$];
   mips_pkg::reg_idx_t e_reg;
   mips_pkg::word_t    e_val;

   string              cur_name = "none";
   int                 got = 0;
   int                 errs = 0;
   int                 passes = 0;
   int                 fails = 0;
   logic [31:0]        rng = 32'hcc46_700a;

   mips_core i_dut (
      .i_clk        (clk),
      .i_rst        (rst),
      .i_imem_we    (imem_we),
      .i_imem_addr  (imem_addr),
      .i_imem_wdata (imem_wdata),
      .o_wb_en      (wb_en),
      .o_wb_reg     (wb_reg),
      .o_wb_data    (wb_data)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic int rand_imm();
      rng = xorshift(rng);
      return int'(rng[15:0]);
   endfunction

   // instruction encoders
   function automatic mips_pkg::word_t r_type(input mips_pkg::field_t fn,
                                              input int rd, input int rs, input int rt);
      return {mips_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
   endfunction

   function automatic mips_pkg::word_t i_type(input mips_pkg::field_t op,
                                              input int rt, input int rs, input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   // a jump to its own address ends every program
   function automatic mips_pkg::word_t j_type(input int addr);
      return {mips_pkg::OP_J, 26'(addr)};
   endfunction

   task automatic build_table();
      int a;
      for (int t = 0; t < N_TESTS; t++) begin
         for (int k = 0; k < PROG_LEN; k++) begin
            prog[t][k] = mips_pkg::NOP;
         end
      end
      names[0] = "alu_ops";
      n_wb[0]  = 8;
      prog[0][0]  = i_type(mips_pkg::OP_ADDI, 1, 0, rand_imm());
      prog[0][1]  = i_type(mips_pkg::OP_ADDI, 2, 0, rand_imm());
      prog[0][2]  = i_type(mips_pkg::OP_ADDI, 3, 0, rand_imm());
      prog[0][5]  = r_type(mips_pkg::FN_ADDU, 4, 1, 2);
      prog[0][6]  = r_type(mips_pkg::FN_SUBU, 5, 1, 3);
      prog[0][7]  = r_type(mips_pkg::FN_AND, 6, 2, 3);
      prog[0][8]  = r_type(mips_pkg::FN_OR, 7, 1, 3);
      prog[0][9]  = r_type(mips_pkg::FN_SLT, 8, 1, 2);
      prog[0][10] = j_type(10);
      // distance 1 and 2 producers, plus a dropped r0 write
      names[1] = "forwarding";
      n_wb[1]  = 5;
      prog[1][0] = i_type(mips_pkg::OP_ADDI, 1, 0, rand_imm());
      prog[1][1] = r_type(mips_pkg::FN_ADDU, 2, 1, 1);
      prog[1][2] = r_type(mips_pkg::FN_SUBU, 3, 2, 1);
      prog[1][3] = i_type(mips_pkg::OP_ADDI, 0, 1, rand_imm());
      prog[1][4] = r_type(mips_pkg::FN_OR, 4, 3, 2);
      prog[1][5] = r_type(mips_pkg::FN_ADDU, 5, 4, 0);
      prog[1][6] = j_type(6);
      names[2] = "load_store";
      n_wb[2]  = 6;
      prog[2][0] = i_type(mips_pkg::OP_ADDI, 1, 0, rand_imm());
      prog[2][1] = i_type(mips_pkg::OP_SW, 1, 0, 'h0010);
      prog[2][2] = i_type(mips_pkg::OP_LW, 2, 0, 'h0010);
      prog[2][3] = r_type(mips_pkg::FN_ADDU, 3, 2, 1);
      prog[2][4] = i_type(mips_pkg::OP_ADDI, 4, 0, rand_imm());
      prog[2][5] = i_type(mips_pkg::OP_SW, 4, 0, 'h0024);
      prog[2][6] = i_type(mips_pkg::OP_LW, 5, 0, 'h0024);
      prog[2][7] = r_type(mips_pkg::FN_SUBU, 6, 5, 4);
      prog[2][8] = j_type(8);
      // not taken right after its operand write, taken right after one, then taken on r0
      names[3] = "branch";
      n_wb[3]  = 5;
      // odd, so a stale zero operand never compares equal to it
      a = rand_imm() | 1;
      prog[3][0]  = i_type(mips_pkg::OP_ADDI, 1, 0, a);
      prog[3][1]  = i_type(mips_pkg::OP_ADDI, 2, 0, a ^ 1);
      prog[3][2]  = i_type(mips_pkg::OP_BEQ, 2, 1, 1);
      prog[3][3]  = i_type(mips_pkg::OP_ADDI, 3, 0, 'h0077);
      prog[3][4]  = i_type(mips_pkg::OP_ADDI, 4, 0, a);
      prog[3][5]  = i_type(mips_pkg::OP_BEQ, 4, 1, 1);
      prog[3][6]  = i_type(mips_pkg::OP_ADDI, 5, 0, 'h0055);
      prog[3][7]  = i_type(mips_pkg::OP_BEQ, 0, 0, 1);
      prog[3][8]  = i_type(mips_pkg::OP_ADDI, 6, 0, 'h0066);
      prog[3][9]  = i_type(mips_pkg::OP_ADDI, 7, 5, 1);
      prog[3][10] = j_type(10);
      names[4] = "jump";
      n_wb[4]  = 3;
      prog[4][0] = i_type(mips_pkg::OP_ADDI, 1, 0, rand_imm());
      prog[4][1] = j_type(4);
      prog[4][2] = i_type(mips_pkg::OP_ADDI, 2, 0, 'h0022);
      prog[4][3] = i_type(mips_pkg::OP_ADDI, 3, 0, 'h0033);
      prog[4][4] = r_type(mips_pkg::FN_ADDU, 4, 1, 1);
      prog[4][5] = i_type(mips_pkg::OP_ADDI, 5, 4, rand_imm());
      prog[4][6] = j_type(6);
   endtask

   // instruction-set interpreter, one instruction per step
   task automatic run_model(input int t);
      mips_pkg::word_t    regs [32];
      mips_pkg::word_t    dmem [64];
      mips_pkg::word_t    ins;
      mips_pkg::word_t    a;
      mips_pkg::word_t    b;
      mips_pkg::word_t    imm;
      mips_pkg::word_t    ea;
      mips_pkg::word_t    res;
      mips_pkg::reg_idx_t dst;
      logic               wr;
      int                 pc;
      int                 steps;
      exp_reg.delete();
      exp_val.delete();
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < 64; i++) begin
         dmem[i] = '0;
      end
      pc = 0;
      steps = 0;
      while (steps < 64 && pc >= 0 && pc < PROG_LEN) begin
         ins = prog[t][pc];
         a   = regs[ins[25:21]];
         b   = regs[ins[20:16]];
         imm = {{16{ins[15]}}, ins[15:0]};
         ea  = a + imm;
         res = '0;
         dst = ins[20:16];
         wr  = 1'b0;
         if (ins[31:26] == mips_pkg::OP_J) begin
            if (int'(ins[25:0]) == pc) begin
               break;
            end
            pc = int'(ins[25:0]);
         end else begin
            pc = pc + 1;
            case (ins[31:26])
               mips_pkg::OP_RTYPE: begin
                  dst = ins[15:11];
                  wr  = 1'b1;
                  case (ins[5:0])
                     mips_pkg::FN_ADDU: res = a + b;
                     mips_pkg::FN_SUBU: res = a - b;
                     mips_pkg::FN_AND:  res = a & b;
                     mips_pkg::FN_OR:   res = a | b;
                     mips_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                     default:           wr = 1'b0;
                  endcase
               end
               mips_pkg::OP_ADDI: begin
                  res = ea;
                  wr  = 1'b1;
               end
               mips_pkg::OP_LW: begin
                  res = dmem[ea[7:2]];
                  wr  = 1'b1;
               end
               mips_pkg::OP_SW:  dmem[ea[7:2]] = b;
               mips_pkg::OP_BEQ: begin
                  if (a == b) begin
                     pc = pc + int'(imm);
                  end
               end
               default: wr = 1'b0;
            endcase
            // r0 stays zero and never retires
            if (wr && dst != '0) begin
               regs[dst] = res;
               exp_reg.push_back(dst);
               exp_val.push_back(res);
            end
         end
         steps++;
      end
   endtask

   // writeback monitor, sampled mid-cycle
   always @(negedge clk) begin
      if (wb_en) begin
         if (exp_reg.size() == 0) begin
            $display("%s: unexpected writeback to r%0d after the last expected write",
                     cur_name, wb_reg);
            errs++;
         end else begin
            e_reg = exp_reg.pop_front();
            e_val = exp_val.pop_front();
            if (wb_reg !== e_reg || wb_data !== e_val) begin
               $display("ERROR %s: writeback %0d expected r%0d = %08h, got r%0d = %08h",
                        cur_name, got, e_reg, e_val, wb_reg, wb_data);
               errs++;
            end
         end
         got = got + 1;
      end
   end

   task automatic run_test(input int t);
      run_model(t);
      cur_name = names[t];
      errs = 0;
      got = 0;
      if (exp_reg.size() != n_wb[t]) begin
         $display("%s: interpreter gives %0d writebacks but the table expects %0d",
                  cur_name, exp_reg.size(), n_wb[t]);
         errs++;
      end
      // reset stays high while the program loads, then 4 more cycles
      @(posedge clk);
      rst <= 1'b1;
      for (int k = 0; k < PROG_LEN; k++) begin
         @(posedge clk);
         imem_we    <= 1'b1;
         imem_addr  <= 6'(k);
         imem_wdata <= prog[t][k];
      end
      @(posedge clk);
      imem_we <= 1'b0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      while (got < n_wb[t]) begin
         @(posedge clk);
      end
      // quiet window catches writes that should have been squashed
      repeat (10) @(posedge clk);
      if (exp_reg.size() != 0) begin
         $display("%s: %0d expected writebacks never appeared", cur_name, exp_reg.size());
         errs++;
      end
      if (errs == 0) begin
         passes++;
         $display("%s: ok, %0d writebacks checked", cur_name, got);
      end else begin
         fails++;
         $display("%s: failed with %0d errors", cur_name, errs);
      end
   endtask

   initial begin
      build_table();
      for (int t = 0; t < N_TESTS; t++) begin
         run_test(t);
      end
      $display("%0d tests passed, %0d tests failed", passes, fails);
      if (fails == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // watchdog, budget scales with the expected writebacks
   initial begin
      int budget;
      @(posedge clk);
      budget = 0;
      for (int t = 0; t < N_TESTS; t++) begin
         budget += 40 * n_wb[t];
      end
      repeat (budget) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles, stuck in test %s",
               budget, cur_name);
      $display("Result: FAILED");
      $finish;
   end

endmodule

// File: mips_core.f
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/mips_core.sv
sim/tb_mips_core.sv

// File: Makefile
# Verilator build and run for the pipelined MIPS core

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
